/* Bender.yml */
package:
  name: dma

export_include_dirs:
  - rtl

sources:
  - rtl/dma_desc_pkg.sv
  - rtl/dma_bus_pkg.sv
  - rtl/dma_if.sv
  - rtl/dma_regs.sv
  - rtl/dma_desc_store.sv
  - rtl/dma_ctrl.sv
  - rtl/dma_top.sv
  - target: test
    files:
      - verif/dma_mem_model.sv
      - verif/dma_tb.sv

/* dma.f */
+incdir+rtl
rtl/dma_desc_pkg.sv
rtl/dma_bus_pkg.sv
rtl/dma_if.sv
rtl/dma_regs.sv
rtl/dma_desc_store.sv
rtl/dma_ctrl.sv
rtl/dma_top.sv
verif/dma_mem_model.sv
verif/dma_tb.sv

/* rtl/dma_bus_pkg.sv */
/*
 * Bus side types
 * controller states and slave register index
 */
package dma_bus_pkg;

   typedef enum logic [3:0] {
      st_idle,
      st_fetch0,
      st_next0,
      st_fetch1,
      st_wait0,
      st_ctl0,
      st_done0,
      st_wait1,
      st_ctl1,
      st_done1,
      st_next1
   } dma_state_e;

   typedef logic [1:0] dma_reg_idx_t;   // slave word index

endpackage

/* rtl/dma_config.svh */
/*
 * DMA controller configuration
 * bus widths, burst length and slave register word offsets
 */
`ifndef DMA_CONFIG_SVH
`define DMA_CONFIG_SVH

`define DMA_ADR_W    32
`define DMA_DAT_W    32      // one half of the 64-bit master bus
`define DMA_BEATS    4       // beats per descriptor or status burst
`define DMA_CNT_W    24      // count field of the control word

`define DMA_REG_CSR  2'd0
`define DMA_REG_NDAR 2'd1
`define DMA_REG_DAR  2'd2

`endif

/* rtl/dma_ctrl.sv */
/*
 * DMA controller state machine
 * fetches descriptors, waits for the slots, writes status back and chains
 */
`timescale 1ns/1ps
`include "dma_config.svh"

module dma_ctrl
   import dma_bus_pkg::*;
   import dma_desc_pkg::*;
(
   input  logic                    wb_clk_i,
   input  logic                    wb_rst_i,
   output logic                    wbm_cyc_o,
   output logic                    wbm_stb_o,
   output logic                    wbm_we_o,
   output logic                    wbm_cab_o,
   output logic [2*`DMA_DAT_W/8-1:0] wbm_sel_o,
   output logic [`DMA_ADR_W-1:0]   wbm_adr_o,
   output logic [2*`DMA_DAT_W-1:0] wbm_dat_o,
   input  logic [2*`DMA_DAT_W-1:0] wbm_dat_i,
   input  logic                    wbm_ack_i,
   input  logic                    wbm_err_i,
   input  logic                    wbm_rty_i,
   input  logic [1:0]              c_done_i,
   output logic [1:0]              m_enable_o,
   dma_reg_if.ctrl                 regs,
   dma_desc_if.ctrl                desc
);

   localparam dma_beat_t last_beat = dma_beat_t'(`DMA_BEATS - 1);

   dma_state_e            state;
   dma_state_e            state_n;
   dma_ctrl_word_u        w0;
   dma_ctrl_word_u        w1;
   dma_qaddr_t            adr_q;
   dma_qaddr_t            start_adr;
   dma_qaddr_t            cdar;
   dma_qaddr_t            dar_q;
   dma_beat_t             beat;
   logic [`DMA_DAT_W-1:0] cnt0;
   logic [`DMA_DAT_W-1:0] cnt1;
   logic [1:0]            en_n;
   logic                  beat_ok;
   logic                  last_ok;
   logic                  start;
   logic                  start_we;
   logic                  append_mode;
   logic                  append_mode_n;
   logic                  dirty_clr_n;
   logic                  append_clr_n;

   assign w0      = {8'h00, desc.dc0};
   assign w1      = {8'h00, desc.dc1};
   assign beat_ok = wbm_stb_o & wbm_ack_i & ~wbm_rty_i & ~wbm_err_i;   // retry holds the beat
   assign last_ok = beat_ok & (beat == last_beat);

   always_comb begin
      state_n       = state;
      start         = 1'b0;
      start_we      = 1'b0;
      start_adr     = desc.next_desc;
      dirty_clr_n   = 1'b0;
      append_clr_n  = 1'b0;
      append_mode_n = append_mode;
      en_n          = m_enable_o;
      case (state)
         st_idle: begin
            if (regs.enable && regs.ndar_dirty) begin
               dirty_clr_n = 1'b1;
               start       = 1'b1;
               start_adr   = regs.ndar;
               state_n     = st_fetch0;
            end else if (regs.enable && regs.append) begin
               append_mode_n = 1'b1;   // re-read last descriptor for its new link
               start         = 1'b1;
               start_adr     = dar_q;
               state_n       = st_fetch0;
            end
         end
         st_fetch0: begin
            if (last_ok)
               state_n = st_next0;
         end
         st_next0: begin
            if (w0.f.chain) begin
               start   = 1'b1;
               state_n = append_mode ? st_fetch0 : st_fetch1;
            end else begin
               state_n = append_mode ? st_idle : st_wait0;
            end
            if (append_mode) begin
               append_clr_n  = 1'b1;
               append_mode_n = 1'b0;
            end else begin
               en_n[0] = 1'b1;
            end
         end
         st_fetch1: begin
            if (last_ok)
               state_n = st_wait0;
         end
         st_wait0: begin
            if (w0.f.chain)
               en_n[1] = 1'b1;
            if (c_done_i[0]) begin
               if (w0.f.wb) begin
                  start     = 1'b1;
                  start_we  = 1'b1;
                  start_adr = desc.ctl_adr0;
                  state_n   = st_ctl0;
               end else begin
                  state_n = st_done0;
               end
            end
         end
         st_ctl0: begin
            if (last_ok)
               state_n = st_done0;
         end
         st_done0: begin
            en_n[0] = 1'b0;
            state_n = w0.f.chain ? st_wait1 : st_idle;
         end
         st_wait1: begin
            if (c_done_i[1]) begin
               if (w1.f.wb) begin
                  start     = 1'b1;
                  start_we  = 1'b1;
                  start_adr = desc.ctl_adr1;
                  state_n   = st_ctl1;
               end else begin
                  state_n = st_done1;
               end
            end
         end
         st_ctl1: begin
            if (last_ok)
               state_n = st_done1;
         end
         st_done1: begin
            en_n[1] = 1'b0;
            state_n = w1.f.chain ? st_next1 : st_idle;
         end
         st_next1: begin
            start   = 1'b1;
            state_n = st_fetch0;
         end
         default: state_n = st_idle;
      endcase
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         state             <= st_idle;
         append_mode       <= 1'b0;
         m_enable_o        <= 2'b00;
         regs.dirty_clear  <= 1'b0;
         regs.append_clear <= 1'b0;
         desc.reset0       <= 1'b0;
         desc.reset1       <= 1'b0;
         dar_q             <= '0;
      end else begin
         state             <= state_n;
         append_mode       <= append_mode_n;
         m_enable_o        <= en_n;
         regs.dirty_clear  <= dirty_clr_n;
         regs.append_clear <= append_clr_n;
         desc.reset0       <= (state == st_done0);
         desc.reset1       <= (state == st_done1);
         if (state == st_done0 || state == st_done1)
            dar_q <= cdar;
      end
   end

   // burst master, strobe held until the last counted beat
   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         wbm_cyc_o <= 1'b0;
         wbm_stb_o <= 1'b0;
         wbm_we_o  <= 1'b0;
         adr_q     <= '0;
         beat      <= '0;
      end else if (start) begin
         wbm_cyc_o <= 1'b1;
         wbm_stb_o <= 1'b1;
         wbm_we_o  <= start_we;
         adr_q     <= start_adr;
         beat      <= '0;
      end else if (beat_ok) begin
         adr_q <= adr_q + 1'b1;   // 8 bytes per beat
         beat  <= beat + 1'b1;
         if (beat == last_beat) begin
            wbm_cyc_o <= 1'b0;
            wbm_stb_o <= 1'b0;
         end
      end
   end

   always_ff @(posedge wb_clk_i) begin
      if (desc.capture && beat == '0)
         cdar <= adr_q;   // address of the descriptor being read
   end

   // elapsed cycles since each slot was enabled
   always_ff @(posedge wb_clk_i) begin
      cnt0 <= (en_n[0] & ~m_enable_o[0]) ? '0 : cnt0 + 1'b1;
      cnt1 <= (en_n[1] & ~m_enable_o[1]) ? '0 : cnt1 + 1'b1;
   end

   assign wbm_cab_o = 1'b1;
   assign wbm_sel_o = '1;
   assign wbm_adr_o = {adr_q, 3'b000};
   assign wbm_dat_o = {{`DMA_DAT_W{1'b0}}, (beat == '0) ? cnt0 : cnt1};

   assign desc.capture = beat_ok & ~wbm_we_o & (state == st_fetch0 || state == st_fetch1);
   assign desc.slot    = (state == st_fetch1);
   assign desc.wr_en   = ~append_mode;   // append re-read skips slot 0
   assign desc.beat    = beat;
   assign desc.rdata   = wbm_dat_i;
   assign desc.done0   = (state == st_done0);
   assign desc.done1   = (state == st_done1);

   assign regs.busy    = (state != st_idle);
   assign regs.dar     = dar_q;
   assign regs.int_set = (state == st_done0 && w0.f.irq) || (state == st_done1 && w1.f.irq);

   a_stb_in_cyc: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      wbm_stb_o |-> wbm_cyc_o);

   a_state_legal: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      !$isunknown(state) && state <= st_next1);

endmodule

/* rtl/dma_desc_pkg.sv */
/*
 * Descriptor layout types
 * the control word is carried raw to the slots and decoded by the controller
 */
`include "dma_config.svh"

package dma_desc_pkg;

   typedef logic [`DMA_ADR_W-1:3] dma_qaddr_t;   // 64-bit aligned address
   typedef logic [`DMA_CNT_W-1:0] dma_count_t;
   typedef logic [2:0]            dma_beat_t;    // counted beats in a burst

   // flag bits sit inside the 24-bit count, as the slots expect
   typedef struct packed {
      logic [7:0] rsvd;
      logic [7:0] cnt_hi;
      logic       irq;       // interrupt after done
      logic       chain;     // next descriptor goes to slot 1
      logic [5:0] cnt_mid;
      logic       wb;        // status write-back
      logic [6:0] cnt_lo;
   } dma_ctrl_fields_t;

   typedef union packed {
      logic [31:0]      raw;   // word as handed to the slot
      dma_ctrl_fields_t f;     // controller view
   } dma_ctrl_word_u;

endpackage

/* rtl/dma_desc_store.sv */
/*
 * Descriptor store
 * keeps link, write-back address and count per slot, and feeds the slots
 */
`timescale 1ns/1ps
`include "dma_config.svh"

module dma_desc_store
   import dma_desc_pkg::*;
(
   input  logic                  wb_clk_i,
   input  logic                  wb_rst_i,
   dma_desc_if.store             desc,
   output logic [1:0]            ss_we_o,
   output logic [1:0]            ss_adr_o,
   output logic [`DMA_DAT_W-1:0] ss_dat_o,
   output dma_count_t            ss_dc0_o,
   output dma_count_t            ss_dc1_o,
   output logic [1:0]            ss_done_o
);

   dma_ctrl_word_u ctl_w;
   logic           cap0;
   logic           cap1;

   assign ctl_w = desc.rdata[`DMA_DAT_W-1:0];   // beat 1 low word
   assign cap0  = desc.capture & ~desc.slot;
   assign cap1  = desc.capture & desc.slot;

   always_ff @(posedge wb_clk_i) begin
      if (desc.capture && desc.beat == 3'd0) begin
         desc.next_desc <= desc.rdata[`DMA_ADR_W-1:3];
         if (desc.slot)
            desc.ctl_adr1 <= desc.rdata[`DMA_DAT_W+`DMA_ADR_W-1:`DMA_DAT_W+3];
         else
            desc.ctl_adr0 <= desc.rdata[`DMA_DAT_W+`DMA_ADR_W-1:`DMA_DAT_W+3];
      end
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         desc.dc0 <= '0;
         desc.dc1 <= '0;
      end else begin
         if (cap0 && desc.beat == 3'd1)
            desc.dc0 <= ctl_w.raw[`DMA_CNT_W-1:0];
         else if (desc.reset0)
            desc.dc0 <= '0;
         if (cap1 && desc.beat == 3'd1)
            desc.dc1 <= ctl_w.raw[`DMA_CNT_W-1:0];
         else if (desc.reset1)
            desc.dc1 <= '0;
      end
   end

   assign ss_we_o   = {cap1, cap0} & {2{desc.wr_en}};
   assign ss_adr_o  = desc.beat[1:0];
   assign ss_dat_o  = desc.rdata[`DMA_DAT_W-1:0];
   assign ss_dc0_o  = desc.dc0;
   assign ss_dc1_o  = desc.dc1;
   assign ss_done_o = {desc.done1, desc.done0};

   a_capture_beat: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      desc.capture |-> (desc.beat < `DMA_BEATS));

endmodule

/* rtl/dma_if.sv */
/*
 * DMA internal links
 * register file to controller, and controller to descriptor store
 */
`timescale 1ns/1ps
`include "dma_config.svh"

interface dma_reg_if
   import dma_desc_pkg::*;
();
   logic       enable;
   logic       append;
   dma_qaddr_t ndar;
   logic       ndar_dirty;
   logic       dirty_clear;    // one-cycle pulse
   logic       append_clear;   // one-cycle pulse
   logic       int_set;        // one-cycle pulse
   logic       busy;
   dma_qaddr_t dar;

   modport regs (output enable, append, ndar, ndar_dirty,
                 input  dirty_clear, append_clear, int_set, busy, dar);
   modport ctrl (input  enable, append, ndar, ndar_dirty,
                 output dirty_clear, append_clear, int_set, busy, dar);
endinterface

interface dma_desc_if
   import dma_desc_pkg::*;
();
   logic                      capture;   // accepted read beat
   logic                      slot;
   logic                      wr_en;     // forward beat to the slot
   dma_beat_t                 beat;
   logic [2*`DMA_DAT_W-1:0]   rdata;
   logic                      done0;
   logic                      done1;
   logic                      reset0;
   logic                      reset1;
   dma_qaddr_t                next_desc;
   dma_qaddr_t                ctl_adr0;
   dma_qaddr_t                ctl_adr1;
   dma_count_t                dc0;
   dma_count_t                dc1;

   modport ctrl  (output capture, slot, wr_en, beat, rdata, done0, done1, reset0, reset1,
                  input  next_desc, ctl_adr0, ctl_adr1, dc0, dc1);
   modport store (input  capture, slot, wr_en, beat, rdata, done0, done1, reset0, reset1,
                  output next_desc, ctl_adr0, ctl_adr1, dc0, dc1);
endinterface

/* rtl/dma_regs.sv */
/*
 * DMA slave register file
 * CSR, next descriptor address and current descriptor address
 */
`timescale 1ns/1ps
`include "dma_config.svh"

module dma_regs
   import dma_bus_pkg::*;
(
   input  logic                  wb_clk_i,
   input  logic                  wb_rst_i,
   input  logic                  wbs_cyc_i,
   input  logic                  wbs_stb_i,
   input  logic                  wbs_we_i,
   input  dma_reg_idx_t          wbs_adr_i,
   input  logic [`DMA_DAT_W-1:0] wbs_dat_i,
   output logic [`DMA_DAT_W-1:0] wbs_dat_o,
   output logic                  wbs_ack_o,
   output logic                  int_o,
   dma_reg_if.regs               regs
);

   logic [`DMA_DAT_W-1:0] rd_data;
   logic                  acc;
   logic                  wr_csr;
   logic                  wr_ndar;

   assign acc     = wbs_cyc_i & wbs_stb_i & ~wbs_ack_o;   // single access
   assign wr_csr  = acc & wbs_we_i & (wbs_adr_i == `DMA_REG_CSR);
   assign wr_ndar = acc & wbs_we_i & (wbs_adr_i == `DMA_REG_NDAR);

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         wbs_ack_o       <= 1'b0;
         regs.enable     <= 1'b0;
         regs.append     <= 1'b0;
         regs.ndar_dirty <= 1'b0;
         int_o           <= 1'b0;
      end else begin
         wbs_ack_o <= acc;
         if (wr_csr)
            regs.enable <= wbs_dat_i[0];
         if (wr_csr && wbs_dat_i[1])
            regs.append <= 1'b1;
         else if (regs.append_clear)
            regs.append <= 1'b0;
         if (wr_ndar)
            regs.ndar_dirty <= 1'b1;
         else if (regs.dirty_clear)
            regs.ndar_dirty <= 1'b0;
         if (wr_csr && wbs_dat_i[2])   // write 1 to clear, beats a set
            int_o <= 1'b0;
         else if (regs.int_set)
            int_o <= 1'b1;
      end
   end

   always_ff @(posedge wb_clk_i) begin
      if (wr_ndar)
         regs.ndar <= wbs_dat_i[`DMA_ADR_W-1:3];
   end

   always_comb begin
      case (wbs_adr_i)
         `DMA_REG_CSR:  rd_data = {{(`DMA_DAT_W-4){1'b0}}, regs.busy, int_o,
                                   regs.append, regs.enable};
         `DMA_REG_NDAR: rd_data = {regs.ndar, 3'b000};
         `DMA_REG_DAR:  rd_data = {regs.dar, 3'b000};
         default:       rd_data = '0;
      endcase
   end

   always_ff @(posedge wb_clk_i) begin
      if (acc)
         wbs_dat_o <= rd_data;   // busy sampled live
   end

endmodule

/* rtl/dma_top.sv */
/*
 * DMA controller top level
 * register file, burst controller and descriptor store on plain ports
 */
`timescale 1ns/1ps
`include "dma_config.svh"

module dma_top (
   input  logic                      wb_clk_i,
   input  logic                      wb_rst_i,
   // slave bus
   input  logic                      wbs_cyc_i,
   input  logic                      wbs_stb_i,
   input  logic                      wbs_we_i,
   input  logic [1:0]                wbs_adr_i,   // register word index
   input  logic [`DMA_DAT_W-1:0]     wbs_dat_i,
   output logic [`DMA_DAT_W-1:0]     wbs_dat_o,
   output logic                      wbs_ack_o,
   // master bus
   output logic                      wbm_cyc_o,
   output logic                      wbm_stb_o,
   output logic                      wbm_we_o,
   output logic                      wbm_cab_o,
   output logic [2*`DMA_DAT_W/8-1:0] wbm_sel_o,
   output logic [`DMA_ADR_W-1:0]     wbm_adr_o,
   output logic [2*`DMA_DAT_W-1:0]   wbm_dat_o,
   input  logic [2*`DMA_DAT_W-1:0]   wbm_dat_i,
   input  logic                      wbm_ack_i,
   input  logic                      wbm_err_i,
   input  logic                      wbm_rty_i,
   // channel slots
   input  logic [1:0]                c_done_i,
   output logic [1:0]                m_enable_o,
   output logic [1:0]                ss_we_o,
   output logic [1:0]                ss_adr_o,
   output logic [`DMA_DAT_W-1:0]     ss_dat_o,
   output logic [`DMA_CNT_W-1:0]     ss_dc0_o,
   output logic [`DMA_CNT_W-1:0]     ss_dc1_o,
   output logic [1:0]                ss_done_o,
   output logic                      int_o
);

   dma_reg_if  reg_link ();
   dma_desc_if desc_link ();

   dma_regs i_regs (
      .*,
      .regs (reg_link)
   );

   dma_ctrl i_ctrl (
      .*,
      .regs (reg_link),
      .desc (desc_link)
   );

   dma_desc_store i_store (
      .*,
      .desc (desc_link)
   );

endmodule

/* verif/dma_mem_model.sv */
/*
 * DMA bus memory model
 * 64-bit burst slave with random stalls and retry beats, reports write beats
 */
`timescale 1ns/1ps

module dma_mem_model (
   input  logic        clk_i,
   input  logic        rst_i,
   input  logic        cyc_i,
   input  logic        stb_i,
   input  logic        we_i,
   input  logic [31:0] adr_i,
   input  logic [63:0] dat_i,
   output logic [63:0] dat_o,
   output logic        ack_o,
   output logic        rty_o,
   output logic        log_vld_o,   // one pulse per accepted write beat
   output logic [31:0] log_adr_o,
   output logic [63:0] log_dat_o
);

   logic [63:0] mem [0:255];
   logic [2:0]  pick;

   initial begin
      for (int i = 0; i < 256; i++)
         mem[i] = {32'hc0de_0000 ^ i, 32'(i) << 3};   // word tagged with its address
   end

   task automatic put_word(input int idx, input logic [63:0] d);
      mem[idx] = d;
   endtask

   always @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         ack_o     <= 1'b0;
         rty_o     <= 1'b0;
         dat_o     <= '0;
         log_vld_o <= 1'b0;
         log_adr_o <= '0;
         log_dat_o <= '0;
      end else begin
         log_vld_o <= ack_o & ~rty_o & we_i;   // beat the master counts
         log_adr_o <= adr_i;
         log_dat_o <= dat_i;
         if (ack_o && !rty_o && we_i)
            mem[adr_i[10:3]] <= dat_i;
         if (ack_o) begin
            ack_o <= 1'b0;   // one idle cycle between beats
            rty_o <= 1'b0;
         end else if (cyc_i && stb_i) begin
            pick = 3'($urandom % 8);
            if (pick == 3'd2) begin
               ack_o <= 1'b1;   // retry, beat not counted
               rty_o <= 1'b1;
            end else if (pick > 3'd2) begin
               ack_o <= 1'b1;
               dat_o <= mem[adr_i[10:3]];
            end
         end
      end
   end

endmodule

/* verif/dma_tb.sv */
/*
 * DMA controller testbench
 * single, chained, write-back, interrupt and append runs against a reference walk
 */
`timescale 1ns/1ps

module dma_tb;

   localparam int n_desc     = 8;
   localparam int max_cycles = 200 * n_desc * 4;
   localparam logic [31:0] f_chain = 32'h4000;
   localparam logic [31:0] f_irq   = 32'h8000;
   localparam logic [31:0] f_wb    = 32'h0080;

   logic        wb_clk_i;
   logic        wb_rst_i;
   logic        wbs_cyc_i;
   logic        wbs_stb_i;
   logic        wbs_we_i;
   logic [1:0]  wbs_adr_i;
   logic [31:0] wbs_dat_i;
   logic [31:0] wbs_dat_o;
   logic        wbs_ack_o;
   logic        wbm_cyc_o;
   logic        wbm_stb_o;
   logic        wbm_we_o;
   logic        wbm_cab_o;
   logic [7:0]  wbm_sel_o;
   logic [31:0] wbm_adr_o;
   logic [63:0] wbm_dat_o;
   logic [63:0] wbm_dat_i;
   logic        wbm_ack_i;
   logic        wbm_err_i;
   logic        wbm_rty_i;
   logic [1:0]  c_done_i;
   logic [1:0]  m_enable_o;
   logic [1:0]  ss_we_o;
   logic [1:0]  ss_adr_o;
   logic [31:0] ss_dat_o;
   logic [23:0] ss_dc0_o;
   logic [23:0] ss_dc1_o;
   logic [1:0]  ss_done_o;
   logic        int_o;
   logic        log_vld;
   logic [31:0] log_adr;
   logic [63:0] log_dat;

   logic [63:0] ref_mem [0:255];
   logic [34:0] exp_wr[$];     // slot, beat, data
   logic [34:0] exp_wb[$];     // slot, beat, address
   logic [24:0] exp_done[$];   // slot, count
   logic        exp_int;
   logic [31:0] exp_dar;
   logic [31:0] rd;
   int          errors;
   int          cycles;
   int          held [2];      // cycles c_done_i stays low after enable
   int          hold [2];

   dma_top i_dma_top (.*);

   dma_mem_model i_mem (
      .clk_i     (wb_clk_i),
      .rst_i     (wb_rst_i),
      .cyc_i     (wbm_cyc_o),
      .stb_i     (wbm_stb_o),
      .we_i      (wbm_we_o),
      .adr_i     (wbm_adr_o),
      .dat_i     (wbm_dat_o),
      .dat_o     (wbm_dat_i),
      .ack_o     (wbm_ack_i),
      .rty_o     (wbm_rty_i),
      .log_vld_o (log_vld),
      .log_adr_o (log_adr),
      .log_dat_o (log_dat)
   );

   initial begin
      wb_clk_i = 1'b0;
      forever #4 wb_clk_i = ~wb_clk_i;
   end

   task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         errors++;
         $display("Mismatch %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic put_desc(input logic [31:0] a, input logic [31:0] nxt,
                           input logic [31:0] wba, input logic [31:0] flags);
      logic [63:0] w [4];
      w[0] = {wba, nxt};
      w[1] = {$urandom, ($urandom & 32'h00ff_3f7f) | flags};
      w[2] = {$urandom, $urandom};
      w[3] = {$urandom, $urandom};
      for (int i = 0; i < 4; i++) begin
         ref_mem[(a >> 3) + i] = w[i];
         i_mem.put_word((a >> 3) + i, w[i]);
      end
   endtask

   function automatic void push_desc(input logic [31:0] a, input logic slot);
      for (int b = 0; b < 4; b++)
         exp_wr.push_back({slot, 2'(b), ref_mem[(a >> 3) + b][31:0]});
   endfunction

   function automatic void push_end(input logic [31:0] a, input logic slot);
      logic [31:0] ctl;
      logic [31:0] wba;
      ctl = ref_mem[(a >> 3) + 1][31:0];
      wba = ref_mem[a >> 3][63:32];
      if (ctl[7]) begin
         for (int b = 0; b < 4; b++)
            exp_wb.push_back({slot, 2'(b), wba + 32'(8 * b)});
      end
      exp_done.push_back({slot, ctl[23:0]});
      if (ctl[15])
         exp_int = 1'b1;
   endfunction

   // walks descriptors from start, slot 0 then its linked slot 1 partner
   function automatic void dma_expect(input logic [31:0] start, input logic append);
      logic [31:0] a;
      logic [31:0] b;
      logic        run;
      a       = start;
      run     = 1'b1;
      exp_dar = start;
      if (append) begin
         run = ref_mem[(a >> 3) + 1][14];   // re-read only yields a new link
         a   = ref_mem[a >> 3][31:0];
      end
      for (int n = 0; n < n_desc && run; n++) begin
         push_desc(a, 1'b0);
         exp_dar = a;
         if (!ref_mem[(a >> 3) + 1][14]) begin
            push_end(a, 1'b0);
            run = 1'b0;
         end else begin
            b = ref_mem[a >> 3][31:0];
            push_desc(b, 1'b1);
            exp_dar = b;
            push_end(a, 1'b0);
            push_end(b, 1'b1);
            run = ref_mem[(b >> 3) + 1][14];
            a   = ref_mem[b >> 3][31:0];
         end
      end
   endfunction

   task automatic reg_write(input logic [1:0] idx, input logic [31:0] d);
      @(posedge wb_clk_i);
      wbs_cyc_i <= 1'b1;
      wbs_stb_i <= 1'b1;
      wbs_we_i  <= 1'b1;
      wbs_adr_i <= idx;
      wbs_dat_i <= d;
      do @(posedge wb_clk_i); while (!wbs_ack_o);
      wbs_cyc_i <= 1'b0;
      wbs_stb_i <= 1'b0;
      wbs_we_i  <= 1'b0;
   endtask

   task automatic reg_read(input logic [1:0] idx, output logic [31:0] d);
      @(posedge wb_clk_i);
      wbs_cyc_i <= 1'b1;
      wbs_stb_i <= 1'b1;
      wbs_adr_i <= idx;
      do @(posedge wb_clk_i); while (!wbs_ack_o);
      d = wbs_dat_o;
      wbs_cyc_i <= 1'b0;
      wbs_stb_i <= 1'b0;
   endtask

   task automatic finish_run();
      logic [31:0] v;
      while (exp_wr.size() != 0 || exp_done.size() != 0 || exp_wb.size() != 0)
         @(posedge wb_clk_i);
      v = 32'h8;
      while (v[3])
         reg_read(2'd0, v);   // wait for busy to drop
      check_val("m_enable_o", m_enable_o, 0);
      reg_read(2'd2, v);
      check_val("dar", v, exp_dar);
   endtask

   // slot side, completion raised a random time after enable
   always @(posedge wb_clk_i) begin
      for (int k = 0; k < 2; k++) begin
         if (wb_rst_i || !m_enable_o[k]) begin
            hold[k]     <= 0;
            held[k]     <= 4 + $urandom % 24;
            c_done_i[k] <= 1'b0;
         end else if (hold[k] == held[k]) begin
            c_done_i[k] <= 1'b1;
         end else begin
            hold[k] <= hold[k] + 1;
         end
      end
   end

   always @(posedge wb_clk_i) begin
      logic [34:0] e;
      logic [24:0] d;
      if (!wb_rst_i) begin
         for (int k = 0; k < 2; k++) begin
            if (ss_we_o[k] && exp_wr.size() == 0) begin
               errors++;
               $display("unexpected write to slot %0d", k);
            end else if (ss_we_o[k]) begin
               check_val("ss_dat_o", {k[0], ss_adr_o, ss_dat_o}, exp_wr.pop_front());
            end
            if (ss_done_o[k] && exp_done.size() == 0) begin
               errors++;
               $display("unexpected done pulse on slot %0d", k);
            end else if (ss_done_o[k]) begin
               d = exp_done.pop_front();
               check_val("ss_done_o", k, d[24]);
               check_val(k ? "ss_dc1_o" : "ss_dc0_o", k ? ss_dc1_o : ss_dc0_o, d[23:0]);
               check_val("m_enable_o", m_enable_o[k], 1);
            end
         end
         if (wbm_stb_o) begin
            check_val("wbm_sel_o", wbm_sel_o, 8'hff);
            check_val("wbm_cab_o", wbm_cab_o, 1);
         end
         if (log_vld && exp_wb.size() == 0) begin
            errors++;
            $display("unexpected bus write at %h", log_adr);
         end else if (log_vld) begin
            e = exp_wb.pop_front();
            check_val("wbm_adr_o", log_adr, e[31:0]);
            check_val("wbm_dat_o_hi", log_dat[63:32], 0);
            if (e[33:32] == 2'd0)
               check_val("wbm_dat_o_ge_held", log_dat[31:0] >= held[e[34]], 1);
         end
      end
   end

   always @(posedge wb_clk_i) begin
      cycles <= cycles + 1;
      if (cycles == max_cycles) begin
         $display("timeout after %0d cycles, the controller hung", cycles);
         $display("Something failed");
         $finish;
      end
   end

   initial begin
      rd        = $urandom(32'h9425_5436);
      wb_rst_i  = 1'b1;
      wbs_cyc_i = 1'b0;
      wbs_stb_i = 1'b0;
      wbs_we_i  = 1'b0;
      wbs_adr_i = 2'd0;
      wbs_dat_i = '0;
      wbm_err_i = 1'b0;
      c_done_i  = 2'b00;
      errors    = 0;
      cycles    = 0;
      exp_int   = 1'b0;
      repeat (2) @(posedge wb_clk_i);
      wb_rst_i <= 1'b0;

      put_desc(32'h100, 32'h0, 32'h700, 32'h0);   // single, no flags
      dma_expect(32'h100, 1'b0);
      reg_write(2'd1, 32'h100);
      reg_write(2'd0, 32'h1);
      finish_run();
      check_val("int_o", int_o, 0);

      put_desc(32'h200, 32'h300, 32'h700, f_chain | f_wb);
      put_desc(32'h300, 32'h400, 32'h780, f_chain | f_wb | f_irq);
      put_desc(32'h400, 32'h500, 32'h700, f_chain);
      put_desc(32'h500, 32'h000, 32'h700, 32'h0);
      dma_expect(32'h200, 1'b0);
      reg_write(2'd1, 32'h200);
      finish_run();
      check_val("int_o", int_o, exp_int);
      reg_read(2'd0, rd);
      check_val("csr_int", rd[2], 1);
      reg_write(2'd0, 32'h5);   // keep enable, clear interrupt
      exp_int = 1'b0;
      reg_read(2'd0, rd);
      check_val("csr_int", rd[2], 0);
      check_val("int_o", int_o, 0);

      put_desc(32'h500, 32'h600, 32'h700, f_chain);   // new link on last descriptor
      put_desc(32'h600, 32'h000, 32'h700, 32'h0);
      dma_expect(32'h500, 1'b1);
      reg_write(2'd0, 32'h3);
      finish_run();
      reg_read(2'd0, rd);
      check_val("csr_append", rd[1], 0);
      check_val("int_o", int_o, exp_int);

      $display("errors: %0d", errors);
      if (errors == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule
